// File: tlb_mmu.f
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_write_ctrl.sv
verilog/tlb_entry.sv
verilog/tlb_hit_select.sv
verilog/tlb_mmu.sv
sim/tlb_mmu_sva.sv
sim/tlb_mmu_tb.sv

// File: Makefile
# Verilator build and run for the tlb_mmu testbench

VERILATOR ?= verilator
TOP       ?= tlb_mmu_tb
FILELIST  ?= tlb_mmu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^sim passed$$'

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tlb_mmu_tb.sv
// tlb_mmu testbench with stimulus table, compare tasks, timeout and reset
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_mmu_tb;

    localparam int         MAX_ROWS   = 40;
    localparam int         RST_CYCLES = 8;
    localparam logic [1:0] OP_WI      = 2'd0;
    localparam logic [1:0] OP_WR      = 2'd1;
    localparam logic [1:0] OP_LOOKUP  = 2'd2;
    localparam logic [1:0] OP_PROBE   = 2'd3;

    localparam logic [`VPN2_W-1:0] VPN_A = 19'h00123;   // tlbwi, index 3
    localparam logic [`VPN2_W-1:0] VPN_B = 19'h01000;   // first tlbwr
    localparam logic [`VPN2_W-1:0] VPN_C = 19'h02000;   // second tlbwr
    localparam logic [`VPN2_W-1:0] VPN_D = 19'h04567;   // global pair
    localparam logic [`VPN2_W-1:0] VPN_E = 19'h05a5a;   // V clear / D clear pages
    localparam logic [`VPN2_W-1:0] VPN_F = 19'h06000;   // only one G bit set
    localparam logic [`VPN2_W-1:0] VPN_X = 19'h33333;   // never written

    logic                   aclk;
    logic                   rst;
    logic [31:0]            i_vaddr;
    logic [31:0]            d_vaddr;
    logic                   d_is_store;
    logic [`ASID_W-1:0]     cur_asid;
    logic [31:0]            entry_hi;
    logic [31:0]            entry_lo0;
    logic [31:0]            entry_lo1;
    logic [`TLB_IDX_W-1:0]  index;
    logic                   tlbwi;
    logic                   tlbwr;
    logic                   tlbp;
    logic [31:0]            i_paddr;
    logic                   i_cached;
    logic [1:0]             i_except;
    logic [31:0]            d_paddr;
    logic                   d_cached;
    logic [1:0]             d_except;
    logic [`TLB_IDX_W-1:0]  probe_index;
    logic                   probe_miss;

    // stimulus and expected values, one entry per row
    string                  row_name  [MAX_ROWS];
    logic [1:0]             row_op    [MAX_ROWS];
    logic [`TLB_IDX_W-1:0]  row_idx   [MAX_ROWS];
    logic [31:0]            row_hi    [MAX_ROWS];
    logic [31:0]            row_lo0   [MAX_ROWS];
    logic [31:0]            row_lo1   [MAX_ROWS];
    logic [31:0]            row_va    [MAX_ROWS];
    logic [`ASID_W-1:0]     row_asid  [MAX_ROWS];
    logic                   row_store [MAX_ROWS];   // d port only when set
    logic [31:0]            row_pa    [MAX_ROWS];
    logic                   row_cached[MAX_ROWS];
    logic [1:0]             row_exc   [MAX_ROWS];
    logic [`TLB_IDX_W-1:0]  row_pidx  [MAX_ROWS];
    logic                   row_miss  [MAX_ROWS];

    int n_rows;
    int seed;
    int cycles;
    int limit;
    int err_addr;
    int err_flag;
    int err_exc;
    int err_idx;

    tlb_mmu i_tlb_mmu (.*);

    always #10 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] make_va(input logic [`VPN2_W-1:0] vpn2, input logic odd,
                                            input logic [11:0] off);
        return {vpn2, odd, off};
    endfunction

    // EntryLo layout {PFN, C, D, V, G}
    function automatic logic [31:0] make_lo(input logic [`PFN_W-1:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b000000, pfn, c, d, v, g};
    endfunction

    function automatic logic [31:0] make_hi(input logic [`VPN2_W-1:0] vpn2,
                                            input logic [`ASID_W-1:0] asid);
        return {vpn2, 5'b00000, asid};
    endfunction

    task automatic add_row(input string name, input logic [1:0] op);
        row_name[n_rows]   = name;
        row_op[n_rows]     = op;
        row_idx[n_rows]    = '0;
        row_hi[n_rows]     = '0;
        row_lo0[n_rows]    = '0;
        row_lo1[n_rows]    = '0;
        row_va[n_rows]     = '0;
        row_asid[n_rows]   = 8'd5;
        row_store[n_rows]  = 1'b0;
        row_pa[n_rows]     = '0;
        row_cached[n_rows] = 1'b0;
        row_exc[n_rows]    = `EXC_NONE;
        row_pidx[n_rows]   = '0;
        row_miss[n_rows]   = 1'b0;
        n_rows++;
    endtask

    task automatic add_write(input string name, input logic [1:0] op,
                             input logic [`TLB_IDX_W-1:0] idx, input logic [31:0] hi,
                             input logic [31:0] lo0, input logic [31:0] lo1);
        add_row(name, op);
        row_idx[n_rows-1] = idx;
        row_hi[n_rows-1]  = hi;
        row_lo0[n_rows-1] = lo0;
        row_lo1[n_rows-1] = lo1;
    endtask

    task automatic add_lookup(input string name, input logic [31:0] va,
                              input logic [`ASID_W-1:0] asid, input logic store,
                              input logic [31:0] pa, input logic cached, input logic [1:0] exc);
        add_row(name, OP_LOOKUP);
        row_va[n_rows-1]     = va;
        row_asid[n_rows-1]   = asid;
        row_store[n_rows-1]  = store;
        row_pa[n_rows-1]     = pa;
        row_cached[n_rows-1] = cached;
        row_exc[n_rows-1]    = exc;
    endtask

    task automatic add_probe(input string name, input logic [31:0] hi,
                             input logic [`TLB_IDX_W-1:0] pidx, input logic miss);
        add_row(name, OP_PROBE);
        row_hi[n_rows-1]   = hi;
        row_pidx[n_rows-1] = pidx;
        row_miss[n_rows-1] = miss;
    endtask

    task automatic build_table();
        logic [11:0] off;
        logic [28:0] rest;
        logic        k0;
        off = 12'($random(seed));
        add_lookup("reset_refill", make_va(VPN_A, 1'b0, off), 8'd5, 1'b0, '0, 1'b0, `EXC_REFILL);
        for (int k = 0; k < 4; k++) begin
            rest = 29'($random(seed));
            k0   = (k % 2 == 0);
            add_lookup($sformatf("kseg_fill_%0d", k), {k0 ? `SEG_KSEG0 : `SEG_KSEG1, rest},
                       8'd5, 1'b0, {3'b000, rest}, k0, `EXC_NONE);   // kseg0 cached only
        end
        // replacement pointer starts at the top entry and counts down
        add_write("wr_first", OP_WR, '0, make_hi(VPN_B, 8'd5),
                  make_lo(20'h11111, 3'd3, 1'b1, 1'b1, 1'b0),
                  make_lo(20'h22222, 3'd2, 1'b1, 1'b1, 1'b0));
        add_write("wr_second", OP_WR, '0, make_hi(VPN_C, 8'd5),
                  make_lo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b0),
                  make_lo(20'h23456, 3'd3, 1'b1, 1'b1, 1'b0));
        off = 12'($random(seed));
        add_lookup("wr_odd_page", make_va(VPN_B, 1'b1, off), 8'd5, 1'b0,
                   {20'h22222, off}, 1'b0, `EXC_NONE);
        add_probe("probe_first", make_hi(VPN_B, 8'd5), 4'd15, 1'b0);
        add_probe("probe_second", make_hi(VPN_C, 8'd5), 4'd14, 1'b0);
        add_probe("probe_unwritten", make_hi(VPN_X, 8'd5), '0, 1'b1);
        // indexed write, even page cacheable, odd page not
        add_write("wi_idx3", OP_WI, 4'd3, make_hi(VPN_A, 8'd5),
                  make_lo(20'h0abcd, 3'd3, 1'b1, 1'b1, 1'b0),
                  make_lo(20'h0beef, 3'd2, 1'b1, 1'b1, 1'b0));
        off = 12'($random(seed));
        add_lookup("even_page", make_va(VPN_A, 1'b0, off), 8'd5, 1'b0,
                   {20'h0abcd, off}, 1'b1, `EXC_NONE);
        off = 12'($random(seed));
        add_lookup("odd_page", make_va(VPN_A, 1'b1, off), 8'd5, 1'b0,
                   {20'h0beef, off}, 1'b0, `EXC_NONE);
        add_lookup("asid_mismatch", make_va(VPN_A, 1'b0, off), 8'd6, 1'b0, '0, 1'b0, `EXC_REFILL);
        add_write("wi_global", OP_WI, 4'd5, make_hi(VPN_D, 8'd5),
                  make_lo(20'h33333, 3'd3, 1'b1, 1'b1, 1'b1),
                  make_lo(20'h44444, 3'd3, 1'b1, 1'b1, 1'b1));
        off = 12'($random(seed));
        add_lookup("global_other_asid", make_va(VPN_D, 1'b1, off), 8'd9, 1'b0,
                   {20'h44444, off}, 1'b1, `EXC_NONE);
        add_write("wi_half_global", OP_WI, 4'd6, make_hi(VPN_F, 8'd5),
                  make_lo(20'h77777, 3'd3, 1'b1, 1'b1, 1'b1),
                  make_lo(20'h78787, 3'd3, 1'b1, 1'b1, 1'b0));
        add_lookup("half_global_mismatch", make_va(VPN_F, 1'b0, off), 8'd9, 1'b0,
                   '0, 1'b0, `EXC_REFILL);
        // even page invalid, odd page valid but clean
        add_write("wi_flags", OP_WI, 4'd7, make_hi(VPN_E, 8'd5),
                  make_lo(20'h55555, 3'd3, 1'b1, 1'b0, 1'b0),
                  make_lo(20'h66666, 3'd3, 1'b0, 1'b1, 1'b0));
        off = 12'($random(seed));
        add_lookup("invalid_page", make_va(VPN_E, 1'b0, off), 8'd5, 1'b0, '0, 1'b0, `EXC_INVALID);
        add_lookup("store_clean", make_va(VPN_E, 1'b1, off), 8'd5, 1'b1,
                   {20'h66666, off}, 1'b1, `EXC_MOD);
        add_lookup("load_clean", make_va(VPN_E, 1'b1, off), 8'd5, 1'b0,
                   {20'h66666, off}, 1'b1, `EXC_NONE);
    endtask

    task automatic check_addr(input string name, input string sig,
                              input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_addr++;
            $display("FAIL %s %s: expected %h, actual %h", name, sig, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string sig,
                              input logic exp, input logic act);
        if (act !== exp) begin
            err_flag++;
            $display("FAIL %s %s: expected %b, actual %b", name, sig, exp, act);
        end
    endtask

    task automatic check_exc(input string name, input string sig,
                             input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            err_exc++;
            $display("FAIL %s %s: expected %0d, actual %0d", name, sig, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input string sig,
                             input logic [`TLB_IDX_W-1:0] exp, input logic [`TLB_IDX_W-1:0] act);
        if (act !== exp) begin
            err_idx++;
            $display("FAIL %s %s: expected %0d, actual %0d", name, sig, exp, act);
        end
    endtask

    task automatic apply_row(input int r);
        tlbwi      = (row_op[r] == OP_WI);
        tlbwr      = (row_op[r] == OP_WR);
        tlbp       = (row_op[r] == OP_PROBE);
        index      = row_idx[r];
        entry_hi   = row_hi[r];
        entry_lo0  = row_lo0[r];
        entry_lo1  = row_lo1[r];
        i_vaddr    = row_va[r];
        d_vaddr    = row_va[r];
        d_is_store = row_store[r];
        cur_asid   = row_asid[r];
    endtask

    task automatic check_row(input int r);
        logic [1:0] i_exc;
        i_exc = (row_exc[r] == `EXC_MOD) ? `EXC_NONE : row_exc[r];   // fetch never stores
        if (row_op[r] == OP_LOOKUP) begin
            check_exc(row_name[r], "i_except", i_exc, i_except);
            if (i_exc == `EXC_NONE) begin
                check_addr(row_name[r], "i_paddr", row_pa[r], i_paddr);
                check_flag(row_name[r], "i_cached", row_cached[r], i_cached);
            end
            check_exc(row_name[r], "d_except", row_exc[r], d_except);
            if (row_exc[r] == `EXC_NONE) begin
                check_addr(row_name[r], "d_paddr", row_pa[r], d_paddr);
                check_flag(row_name[r], "d_cached", row_cached[r], d_cached);
            end
        end else if (row_op[r] == OP_PROBE) begin
            check_flag(row_name[r], "probe_miss", row_miss[r], probe_miss);
            if (!row_miss[r]) begin
                check_idx(row_name[r], "probe_index", row_pidx[r], probe_index);
            end
        end
    endtask

    initial begin
        aclk       = 1'b0;
        rst        = 1'b1;
        i_vaddr    = '0;
        d_vaddr    = '0;
        d_is_store = 1'b0;
        cur_asid   = '0;
        entry_hi   = '0;
        entry_lo0  = '0;
        entry_lo1  = '0;
        index      = '0;
        tlbwi      = 1'b0;
        tlbwr      = 1'b0;
        tlbp       = 1'b0;
        seed       = 29098;
        n_rows     = 0;
        cycles     = 0;
        err_addr   = 0;
        err_flag   = 0;
        err_exc    = 0;
        err_idx    = 0;
        build_table();
        limit = 10 * n_rows + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge aclk);
        #2;
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
            @(posedge aclk);                      // writes land here, lookups are settled
            check_row(r);
            #2;
        end
        tlbwi = 1'b0;
        tlbwr = 1'b0;
        tlbp  = 1'b0;
        $display("errors: addr %0d, flag %0d, exc %0d, idx %0d", err_addr, err_flag, err_exc,
                 err_idx);
        if (err_addr + err_flag + err_exc + err_idx == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim/tlb_mmu_sva.sv
// hit select assertions for one-hot hits, idle probe outputs and kseg exceptions
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_mmu_sva
    import tlb_pkg::*;
(
    input  vaddr_u                  i_vaddr,
    input  vaddr_u                  d_vaddr,
    input  logic                    tlbp,
    input  logic [`TLB_NUM-1:0]     i_hits,
    input  logic [`TLB_NUM-1:0]     d_hits,
    input  logic [`TLB_NUM-1:0]     p_hits,
    input  logic [1:0]              i_except,
    input  logic [1:0]              d_except,
    input  logic [`TLB_IDX_W-1:0]   probe_index,
    input  logic                    probe_miss
);

    logic smp_clk;                        // hit select is combinational, sample mid-cycle

    initial begin
        smp_clk = 1'b0;
        #15;                              // first sample once reset has cleared the entries
        forever begin
            smp_clk = 1'b1;
            #10;
            smp_clk = 1'b0;
            #10;
        end
    end

    assert property (@(posedge smp_clk) $onehot0(i_hits))
        else $error("several entries hit the fetch address");
    assert property (@(posedge smp_clk) $onehot0(d_hits))
        else $error("several entries hit the data address");
    assert property (@(posedge smp_clk) $onehot0(p_hits))
        else $error("several entries hit the probe");
    assert property (@(posedge smp_clk) !tlbp |-> (probe_index == '0 && !probe_miss))
        else $error("probe outputs active without tlbp");
    assert property (@(posedge smp_clk)
        (i_vaddr.seg.seg == `SEG_KSEG0 || i_vaddr.seg.seg == `SEG_KSEG1) |-> i_except == `EXC_NONE)
        else $error("unmapped fetch address raised an exception");
    assert property (@(posedge smp_clk)
        (d_vaddr.seg.seg == `SEG_KSEG0 || d_vaddr.seg.seg == `SEG_KSEG1) |-> d_except == `EXC_NONE)
        else $error("unmapped data address raised an exception");

endmodule

bind tlb_hit_select tlb_mmu_sva u_sva (
    .i_vaddr     (i_vaddr),
    .d_vaddr     (d_vaddr),
    .tlbp        (tlbp),
    .i_hits      (i_hits),
    .d_hits      (d_hits),
    .p_hits      (p_hits),
    .i_except    (i_except),
    .d_except    (d_except),
    .probe_index (probe_index),
    .probe_miss  (probe_miss)
);

// File: verilog/tlb_mmu.sv
// top level joint TLB, write controller, entry array and hit selector
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_mmu (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic [31:0]                   i_vaddr,
    input  logic [31:0]                   d_vaddr,
    input  logic                          d_is_store,
    input  logic [`ASID_W-1:0]            cur_asid,
    input  logic [31:0]                   entry_hi,
    input  logic [31:0]                   entry_lo0,
    input  logic [31:0]                   entry_lo1,
    input  logic [`TLB_IDX_W-1:0]         index,
    input  logic                          tlbwi,
    input  logic                          tlbwr,
    input  logic                          tlbp,
    output logic [31:0]                   i_paddr,
    output logic                          i_cached,
    output logic [1:0]                    i_except,
    output logic [31:0]                   d_paddr,
    output logic                          d_cached,
    output logic [1:0]                    d_except,
    output logic [`TLB_IDX_W-1:0]         probe_index,
    output logic                          probe_miss
);

    logic [`TLB_NUM-1:0]                  we;
    logic [`VPN2_W-1:0]                   wr_vpn2;
    logic [`ASID_W-1:0]                   wr_asid;
    logic                                 wr_g;
    logic [`LO_W-1:0]                     wr_lo0;
    logic [`LO_W-1:0]                     wr_lo1;
    logic [`TLB_NUM-1:0]                  i_hits;
    logic [`TLB_NUM-1:0]                  d_hits;
    logic [`TLB_NUM-1:0]                  p_hits;
    logic [`TLB_NUM-1:0][`LO_W-1:0]       i_los;
    logic [`TLB_NUM-1:0][`LO_W-1:0]       d_los;

    tlb_write_ctrl u_write_ctrl (
        .aclk       (aclk),
        .rst        (rst),
        .tlbwi      (tlbwi),
        .tlbwr      (tlbwr),
        .index      (index),
        .entry_hi   (entry_hi),
        .entry_lo0  (entry_lo0),
        .entry_lo1  (entry_lo1),
        .we         (we),
        .wr_vpn2    (wr_vpn2),
        .wr_asid    (wr_asid),
        .wr_g       (wr_g),
        .wr_lo0     (wr_lo0),
        .wr_lo1     (wr_lo1)
    );

    for (genvar gi = 0; gi < `TLB_NUM; gi++) begin : g_entry
        tlb_entry u_entry (
            .aclk     (aclk),
            .rst      (rst),
            .we       (we[gi]),
            .wr_vpn2  (wr_vpn2),
            .wr_asid  (wr_asid),
            .wr_g     (wr_g),
            .wr_lo0   (wr_lo0),
            .wr_lo1   (wr_lo1),
            .i_vaddr  (i_vaddr),
            .d_vaddr  (d_vaddr),
            .probe_hi (entry_hi),       // tlbp searches with EntryHi
            .cur_asid (cur_asid),
            .i_hit    (i_hits[gi]),
            .d_hit    (d_hits[gi]),
            .p_hit    (p_hits[gi]),
            .i_lo     (i_los[gi]),
            .d_lo     (d_los[gi])
        );
    end

    tlb_hit_select u_hit_select (
        .i_vaddr     (i_vaddr),
        .d_vaddr     (d_vaddr),
        .d_is_store  (d_is_store),
        .tlbp        (tlbp),
        .i_hits      (i_hits),
        .d_hits      (d_hits),
        .p_hits      (p_hits),
        .i_los       (i_los),
        .d_los       (d_los),
        .i_paddr     (i_paddr),
        .d_paddr     (d_paddr),
        .i_cached    (i_cached),
        .d_cached    (d_cached),
        .i_except    (i_except),
        .d_except    (d_except),
        .probe_index (probe_index),
        .probe_miss  (probe_miss)
    );

endmodule

// File: verilog/tlb_hit_select.sv
// hit merge, address translation, exception priority and probe encoder
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_hit_select
    import tlb_pkg::*;
(
    input  vaddr_u                                i_vaddr,
    input  vaddr_u                                d_vaddr,
    input  logic                                  d_is_store,
    input  logic                                  tlbp,
    input  logic [`TLB_NUM-1:0]                   i_hits,
    input  logic [`TLB_NUM-1:0]                   d_hits,
    input  logic [`TLB_NUM-1:0]                   p_hits,
    input  logic [`TLB_NUM-1:0][`LO_W-1:0]        i_los,
    input  logic [`TLB_NUM-1:0][`LO_W-1:0]        d_los,
    output logic [31:0]                           i_paddr,
    output logic [31:0]                           d_paddr,
    output logic                                  i_cached,
    output logic                                  d_cached,
    output logic [1:0]                            i_except,
    output logic [1:0]                            d_except,
    output logic [`TLB_IDX_W-1:0]                 probe_index,
    output logic                                  probe_miss
);

    logic [34:0]            i_res;        // {paddr, cached, except}
    logic [34:0]            d_res;
    logic [`TLB_IDX_W-1:0]  p_enc;

    // shared by the fetch and data ports
    function automatic logic [34:0] translate(
        input vaddr_u                             va,
        input logic [`TLB_NUM-1:0]                hits,
        input logic [`TLB_NUM-1:0][`LO_W-1:0]     los,
        input logic                               is_store
    );
        logic [`LO_W-1:0]   lo;
        logic               unmapped;
        logic [1:0]         exc;
        logic [31:0]        paddr;
        logic               cached;
        lo = '0;
        for (int k = 0; k < `TLB_NUM; k++) begin
            lo = lo | (los[k] & {`LO_W{hits[k]}});   // at most one hit
        end
        unmapped = (va.seg.seg == `SEG_KSEG0) || (va.seg.seg == `SEG_KSEG1);
        if (unmapped) begin
            exc    = `EXC_NONE;
            paddr  = {3'b000, va.seg.rest};
            cached = (va.seg.seg == `SEG_KSEG0);
        end else begin
            if (!(|hits)) begin
                exc = `EXC_REFILL;
            end else if (!lo[`LO_V_BIT]) begin
                exc = `EXC_INVALID;
            end else if (is_store && !lo[`LO_D_BIT]) begin
                exc = `EXC_MOD;
            end else begin
                exc = `EXC_NONE;
            end
            paddr  = {lo[`LO_PFN_MSB -: `PFN_W], va.page.offset};
            cached = (exc == `EXC_NONE) && (lo[`LO_C_MSB -: 3] == `CACHED_C);
        end
        return {paddr, cached, exc};
    endfunction

    assign i_res = translate(i_vaddr, i_hits, i_los, 1'b0);   // fetch never writes
    assign d_res = translate(d_vaddr, d_hits, d_los, d_is_store);

    assign i_paddr  = i_res[34:3];
    assign i_cached = i_res[2];
    assign i_except = i_res[1:0];
    assign d_paddr  = d_res[34:3];
    assign d_cached = d_res[2];
    assign d_except = d_res[1:0];

    // one-hot to binary for tlbp
    always_comb begin
        p_enc = '0;
        for (int k = 0; k < `TLB_NUM; k++) begin
            if (p_hits[k]) begin
                p_enc = p_enc | `TLB_IDX_W'(k);
            end
        end
    end

    assign probe_index = tlbp ? p_enc : '0;
    assign probe_miss  = tlbp & ~(|p_hits);

endmodule

// File: verilog/tlb_entry.sv
// single TLB entry, storage plus fetch, data and probe comparators
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_entry
    import tlb_pkg::*;
(
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [`VPN2_W-1:0]            wr_vpn2,
    input  logic [`ASID_W-1:0]            wr_asid,
    input  logic                          wr_g,
    input  logic [`LO_W-1:0]              wr_lo0,
    input  logic [`LO_W-1:0]              wr_lo1,
    input  vaddr_u                        i_vaddr,
    input  vaddr_u                        d_vaddr,
    input  vaddr_u                        probe_hi,
    input  logic [`ASID_W-1:0]            cur_asid,
    output logic                          i_hit,
    output logic                          d_hit,
    output logic                          p_hit,
    output logic [`LO_W-1:0]              i_lo,
    output logic [`LO_W-1:0]              d_lo
);

    logic                   present;      // entry has been written since reset
    logic [`VPN2_W-1:0]     vpn2;
    logic [`ASID_W-1:0]     asid;
    logic                   g;
    logic [`LO_W-1:0]       lo0;          // even page
    logic [`LO_W-1:0]       lo1;          // odd page
    logic                   asid_ok;      // global or current asid matches

    always_ff @(posedge aclk) begin
        if (rst) begin
            present <= 1'b0;
        end else if (we) begin
            present <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            vpn2 <= wr_vpn2;
            asid <= wr_asid;
            g    <= wr_g;
            lo0  <= wr_lo0;
            lo1  <= wr_lo1;
        end
    end

    assign asid_ok = g | (cur_asid == asid);

    // no segment check here, hit select drops kseg hits
    assign i_hit = present & asid_ok & (i_vaddr.page.vpn2 == vpn2);
    assign d_hit = present & asid_ok & (d_vaddr.page.vpn2 == vpn2);

    // probe compares against the asid held in EntryHi
    assign p_hit = present & (probe_hi.page.vpn2 == vpn2)
                 & (g | (probe_hi.page.offset[`ASID_W-1:0] == asid));

    assign i_lo = i_vaddr.page.odd ? lo1 : lo0;   // even/odd page of the pair
    assign d_lo = d_vaddr.page.odd ? lo1 : lo0;

endmodule

// File: verilog/tlb_write_ctrl.sv
// TLBWI/TLBWR write decode, replacement pointer, one-hot entry write enables
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_write_ctrl
    import tlb_pkg::*;
(
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          tlbwi,
    input  logic                          tlbwr,
    input  logic [`TLB_IDX_W-1:0]         index,
    input  vaddr_u                        entry_hi,
    input  logic [31:0]                   entry_lo0,
    input  logic [31:0]                   entry_lo1,
    output logic [`TLB_NUM-1:0]           we,
    output logic [`VPN2_W-1:0]            wr_vpn2,
    output logic [`ASID_W-1:0]            wr_asid,
    output logic                          wr_g,
    output logic [`LO_W-1:0]              wr_lo0,
    output logic [`LO_W-1:0]              wr_lo1
);

    logic [`TLB_IDX_W-1:0]  rand_ptr;     // replacement pointer for tlbwr
    logic [`TLB_IDX_W-1:0]  target;       // entry being written
    logic                   do_write;

    // counts down from the top entry, wraps at 0
    always_ff @(posedge aclk) begin
        if (rst) begin
            rand_ptr <= `TLB_IDX_W'(`TLB_NUM - 1);
        end else if (tlbwr && !tlbwi) begin   // tlbwi has priority
            if (rand_ptr == '0) begin
                rand_ptr <= `TLB_IDX_W'(`TLB_NUM - 1);
            end else begin
                rand_ptr <= rand_ptr - 1'b1;
            end
        end
    end

    assign target   = tlbwi ? index : rand_ptr;
    assign do_write = tlbwi | tlbwr;

    assign we = do_write ? (`TLB_NUM'(1) << target) : '0;

    // fields broadcast to every entry
    assign wr_vpn2 = entry_hi.page.vpn2;
    assign wr_asid = entry_hi.page.offset[`ASID_W-1:0];
    assign wr_g    = entry_lo0[`LO_G_BIT] & entry_lo1[`LO_G_BIT];   // global only if both pages say so
    assign wr_lo0  = entry_lo0[`LO_W-1:0];
    assign wr_lo1  = entry_lo1[`LO_W-1:0];

endmodule

// File: verilog/tlb_pkg.sv
// virtual address union with segment and page views
`include "tlb_consts.svh"

package tlb_pkg;

    // one 32-bit address, read either by segment or by page
    typedef union packed {
        struct packed {
            logic [2:0]          seg;      // top bits pick kseg0/kseg1
            logic [28:0]         rest;
        } seg;
        struct packed {
            logic [`VPN2_W-1:0]  vpn2;     // even/odd page pair
            logic                odd;      // selects lo1 when set
            logic [11:0]         offset;   // asid sits in the low byte on EntryHi
        } page;
    } vaddr_u;

endpackage

// File: verilog/tlb_consts.svh
// TLB size, entry field widths and positions, exception codes, segment codes
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

`define TLB_NUM      16           // joint TLB entries
`define TLB_IDX_W    4            // log2 of TLB_NUM
`define VPN2_W       19           // virtual page pair number
`define PFN_W        20           // physical frame number
`define ASID_W       8            // address space id

// stored EntryLo word is {PFN, C, D, V, G}
`define LO_W         26
`define LO_PFN_MSB   25
`define LO_C_MSB     5            // 3-bit cache attribute ends here
`define LO_D_BIT     2            // dirty, page writable
`define LO_V_BIT     1            // valid
`define LO_G_BIT     0            // global

`define CACHED_C     3'd3         // cacheable, noncoherent

`define EXC_NONE     2'd0
`define EXC_REFILL   2'd1         // no matching entry
`define EXC_INVALID  2'd2         // entry found, V clear
`define EXC_MOD      2'd3         // store to page with D clear

`define SEG_KSEG0    3'b100       // 0x8000_0000, unmapped cached
`define SEG_KSEG1    3'b101       // 0xa000_0000, unmapped uncached

`endif
